//--- cpu_defines.svh
//**************************************
// CPU defines
// Word, address and register file sizes
//**************************************
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Width of a data word and of an instruction word
`define CPU_XLEN 32

// Both memories are word addressed with an 8 bit address
`define CPU_ADDR_W 8

// Number of words in each memory
`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 256

// General purpose registers and the width of an index into them
`define CPU_REG_COUNT 32
`define CPU_REG_IDX_W 5

`endif

//--- isa_pkg.sv
//**************************************
// ISA package
// Instruction layout and opcode encodings
//**************************************
`include "cpu_defines.svh"

package isa_pkg;

    // Instruction word in R-type layout
    // I-type reuses the low 16 bits as its immediate
    // J-type takes its target from the low bits as well
    typedef struct packed {
        logic [5:0]                opcode;
        logic [`CPU_REG_IDX_W-1:0] rs;
        logic [`CPU_REG_IDX_W-1:0] rt;
        logic [`CPU_REG_IDX_W-1:0] rd;
        logic [4:0]                shamt;
        logic [5:0]                funct;
    } instr_t;

    // Opcodes that the core executes
    // Anything else runs as a no-op
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_ADDI  = 6'd1,
        OP_AND   = 6'd3,
        OP_OR    = 6'd4,
        OP_ANDI  = 6'd5,
        OP_ORI   = 6'd6,
        OP_SHIFT = 6'd7,
        OP_LW    = 6'd8,
        OP_SW    = 6'd9,
        OP_BEQ   = 6'd10,
        OP_BNE   = 6'd11,
        OP_J     = 6'd16,
        OP_SLT   = 6'd19,
        OP_SLTI  = 6'd20
    } opcode_e;

    // Function codes under opcode 0 (add and sub) and opcode 7 (sll and srl)
    typedef enum logic [5:0] {
        FN_ADD_SLL = 6'd0,
        FN_SUB_SRL = 6'd1
    } funct_e;

endpackage

//--- core_pkg.sv
//**************************************
// Core package
// FSM states, ALU ops and datapath bundles
//**************************************
`include "cpu_defines.svh"

package core_pkg;

    typedef enum logic [2:0] {
        ST_LOAD,
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEMWB,
        ST_HALT
    } cpu_state_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_e;

    // How the PC moves after the current instruction
    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JUMP
    } branch_e;

    // Control bundle that the decoder hands to the control unit
    typedef struct packed {
        alu_op_e                   alu_op;
        logic                      use_imm;
        logic [`CPU_XLEN-1:0]      imm;
        logic [`CPU_REG_IDX_W-1:0] dest;
        logic                      reg_write;
        logic                      is_load;
        logic                      is_store;
        branch_e                   branch;
        logic [`CPU_ADDR_W-1:0]    jump_target;
    } decoded_t;

    // One memory write, also used as the store event at the top
    typedef struct packed {
        logic                   en;
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_XLEN-1:0]   data;
    } mem_write_t;

endpackage

//--- word_memory.sv
//**************************************
// Word memory
// One write port and a registered read
//**************************************
`timescale 1ns/100ps
`include "cpu_defines.svh"

module word_memory import core_pkg::*; #(
    parameter int depth = 256
) (
    input  logic                   clk,
    input  mem_write_t             wr,
    input  logic [`CPU_ADDR_W-1:0] rd_addr,
    output logic [`CPU_XLEN-1:0]   rd_data
);

    logic [`CPU_XLEN-1:0] mem [depth];

    always_ff @(posedge clk) begin
        // Write when the port is enabled
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
        // The read address is sampled every cycle
        // A read of the address being written returns the old word
        rd_data <= mem[rd_addr];
    end

endmodule

//--- reg_file.sv
//**************************************
// Register file
// 32 registers, two reads, register 0 is zero
//**************************************
`timescale 1ns/100ps
`include "cpu_defines.svh"

module reg_file (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`CPU_REG_IDX_W-1:0] rs_idx,
    input  logic [`CPU_REG_IDX_W-1:0] rt_idx,
    input  logic                      wr_en,
    input  logic [`CPU_REG_IDX_W-1:0] wr_idx,
    input  logic [`CPU_XLEN-1:0]      wr_data,
    output logic [`CPU_XLEN-1:0]      rs_val,
    output logic [`CPU_XLEN-1:0]      rt_val
);

    logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            // Register 0 never takes a write so it keeps its reset value of zero
            regs[wr_idx] <= wr_data;
        end
    end

    // Both reads are combinational
    assign rs_val = regs[rs_idx];
    assign rt_val = regs[rt_idx];

endmodule

//--- instr_decoder.sv
//**************************************
// Instruction decoder
// Maps opcode and funct to a control bundle
//**************************************
`timescale 1ns/100ps
`include "cpu_defines.svh"

module instr_decoder import isa_pkg::*, core_pkg::*; (
    input  instr_t   ir,
    output decoded_t dec
);

    logic [`CPU_XLEN-1:0] imm_sext;
    logic [`CPU_XLEN-1:0] imm_zext;

    // The immediate is the low 16 bits of the word
    assign imm_sext = {{(`CPU_XLEN-16){ir[15]}}, ir[15:0]};
    assign imm_zext = {{(`CPU_XLEN-16){1'b0}}, ir[15:0]};

    always_comb begin
        // Start from a bundle with nothing enabled
        dec             = '0;
        dec.imm         = imm_sext;
        dec.dest        = ir.rt;
        dec.jump_target = ir[`CPU_ADDR_W-1:0];
        case (opcode_e'(ir.opcode))
            OP_RTYPE, OP_SHIFT: begin
                // Funct picks add or sub, and sll or srl under opcode 7
                dec.dest = ir.rd;
                case (funct_e'(ir.funct))
                    FN_ADD_SLL: begin
                        dec.alu_op    = (ir.opcode == OP_SHIFT) ? ALU_SLL : ALU_ADD;
                        dec.reg_write = 1'b1;
                    end
                    FN_SUB_SRL: begin
                        dec.alu_op    = (ir.opcode == OP_SHIFT) ? ALU_SRL : ALU_SUB;
                        dec.reg_write = 1'b1;
                    end
                    default: dec.reg_write = 1'b0;
                endcase
            end
            OP_AND, OP_OR, OP_SLT: begin
                dec.dest      = ir.rd;
                dec.reg_write = 1'b1;
                dec.alu_op    = (ir.opcode == OP_AND) ? ALU_AND :
                                (ir.opcode == OP_OR)  ? ALU_OR  : ALU_SLT;
            end
            OP_ADDI, OP_SLTI: begin
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.alu_op    = (ir.opcode == OP_ADDI) ? ALU_ADD : ALU_SLT;
            end
            OP_ANDI, OP_ORI: begin
                // Logical immediates are zero extended
                dec.imm       = imm_zext;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.alu_op    = (ir.opcode == OP_ANDI) ? ALU_AND : ALU_OR;
            end
            OP_LW: begin
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.is_load   = 1'b1;
            end
            OP_SW: begin
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                // Compare rs with rt by subtraction and let the zero flag decide
                dec.alu_op = ALU_SUB;
                dec.branch = (ir.opcode == OP_BEQ) ? BR_EQ : BR_NE;
            end
            OP_J: dec.branch = BR_JUMP;
            default: dec.branch = BR_NONE;
        endcase
    end

endmodule

//--- alu.sv
//**************************************
// ALU
// Arithmetic, logic, shift and compare
//**************************************
`timescale 1ns/100ps
`include "cpu_defines.svh"

module alu import core_pkg::*; (
    input  alu_op_e              op,
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    input  logic [4:0]           shamt,
    output logic [`CPU_XLEN-1:0] result,
    output logic                 zero
);

    logic less;

    // Signed compare for slt and slti
    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            // Shifts move the first operand by the shift amount field
            ALU_SLL: result = a << shamt;
            ALU_SRL: result = a >> shamt;
            ALU_SLT: result = {{(`CPU_XLEN-1){1'b0}}, less};
            default: result = '0;
        endcase
    end

    // For beq and bne the result is rs minus rt
    assign zero = (result == '0);

endmodule

//--- cpu_control.sv
//**************************************
// CPU control
// Load pointers, FSM, PC, IR and commit
//**************************************
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_control import isa_pkg::*, core_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      load_sel,
    input  logic [`CPU_XLEN-1:0]      load_word,
    input  logic [`CPU_XLEN-1:0]      imem_data,
    input  logic [`CPU_XLEN-1:0]      dmem_data,
    input  decoded_t                  dec,
    input  logic [`CPU_XLEN-1:0]      rs_val,
    input  logic [`CPU_XLEN-1:0]      rt_val,
    input  logic [`CPU_XLEN-1:0]      alu_result,
    input  logic                      alu_zero,
    output mem_write_t                imem_wr,
    output mem_write_t                dmem_wr,
    output logic [`CPU_ADDR_W-1:0]    imem_addr,
    output logic [`CPU_ADDR_W-1:0]    dmem_addr,
    output instr_t                    ir,
    output logic [`CPU_XLEN-1:0]      alu_b,
    output logic                      reg_wr_en,
    output logic [`CPU_REG_IDX_W-1:0] reg_wr_idx,
    output logic [`CPU_XLEN-1:0]      reg_wr_data,
    output logic                      done
);

    cpu_state_e             state;
    logic [`CPU_ADDR_W-1:0] imem_ptr;
    logic [`CPU_ADDR_W-1:0] dmem_ptr;
    logic [`CPU_ADDR_W-1:0] final_addr;
    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_ADDR_W-1:0] pc_inc;
    logic [`CPU_ADDR_W-1:0] pc_next;
    logic [`CPU_ADDR_W-1:0] mem_addr;
    logic                   loading;
    logic                   br_taken;

    // Loading runs until start is seen high
    assign loading = (state == ST_LOAD) && !start;

    // Load pointers count up separately for each memory
    always_ff @(posedge clk) begin
        if (rst) begin
            imem_ptr <= '0;
            dmem_ptr <= '0;
        end else if (loading) begin
            if (load_sel) begin
                dmem_ptr <= dmem_ptr + 1'b1;
            end else begin
                imem_ptr <= imem_ptr + 1'b1;
            end
        end
    end

    // Instruction memory is only written during loading
    assign imem_wr.en   = loading && !load_sel;
    assign imem_wr.addr = imem_ptr;
    assign imem_wr.data = load_word;

    // lw and sw address the data memory with rs plus the immediate
    // The adder is only as wide as a memory address
    assign mem_addr  = rs_val[`CPU_ADDR_W-1:0] + dec.imm[`CPU_ADDR_W-1:0];
    assign dmem_addr = mem_addr;
    assign imem_addr = pc;

    // Data memory takes load words before start and sw stores in EXECUTE
    always_comb begin
        if (state == ST_EXECUTE) begin
            dmem_wr.en   = dec.is_store;
            dmem_wr.addr = mem_addr;
            dmem_wr.data = rt_val;
        end else begin
            dmem_wr.en   = loading && load_sel;
            dmem_wr.addr = dmem_ptr;
            dmem_wr.data = load_word;
        end
    end

    // Branch decision from the ALU zero flag
    always_comb begin
        case (dec.branch)
            BR_EQ:   br_taken = alu_zero;
            BR_NE:   br_taken = !alu_zero;
            default: br_taken = 1'b0;
        endcase
    end

    // Taken branches are relative to PC+1, j takes an absolute target
    assign pc_inc = pc + 1'b1;
    always_comb begin
        if (dec.branch == BR_JUMP) begin
            pc_next = dec.jump_target;
        end else if (br_taken) begin
            pc_next = pc_inc + dec.imm[`CPU_ADDR_W-1:0];
        end else begin
            pc_next = pc_inc;
        end
    end

    // Main FSM with one instruction in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_LOAD;
            pc         <= '0;
            final_addr <= '0;
        end else begin
            case (state)
                ST_LOAD: begin
                    // The instruction count becomes the end address
                    if (start) begin
                        final_addr <= imem_ptr;
                        state      <= ST_FETCH;
                    end
                end
                ST_FETCH:   state <= (pc == final_addr) ? ST_HALT : ST_DECODE;
                ST_DECODE:  state <= ST_EXECUTE;
                ST_EXECUTE: begin
                    pc    <= pc_next;
                    state <= dec.is_load ? ST_MEMWB : ST_FETCH;
                end
                ST_MEMWB:   state <= ST_FETCH;
                default:    state <= ST_HALT;
            endcase
        end
    end

    // Memory output is valid in DECODE after the read issued in FETCH
    always_ff @(posedge clk) begin
        if (state == ST_DECODE) begin
            ir <= instr_t'(imem_data);
        end
    end

    assign alu_b = dec.use_imm ? dec.imm : rt_val;

    // ALU results commit in EXECUTE, load data one cycle later in MEMWB
    assign reg_wr_en   = ((state == ST_EXECUTE) && dec.reg_write && !dec.is_load) ||
                         (state == ST_MEMWB);
    assign reg_wr_idx  = dec.dest;
    assign reg_wr_data = (state == ST_MEMWB) ? dmem_data : alu_result;

    assign done = (state == ST_HALT);

endmodule

//--- cpu_top.sv
//**************************************
// CPU top
// Control, memories, registers and ALU
//**************************************
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_top import isa_pkg::*, core_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 load_sel,
    input  logic [`CPU_XLEN-1:0] load_word,
    output logic                 done,
    output mem_write_t           store
);

    mem_write_t                imem_wr;
    mem_write_t                dmem_wr;
    logic [`CPU_ADDR_W-1:0]    imem_addr;
    logic [`CPU_ADDR_W-1:0]    dmem_addr;
    logic [`CPU_XLEN-1:0]      imem_data;
    logic [`CPU_XLEN-1:0]      dmem_data;
    instr_t                    ir;
    decoded_t                  dec;
    logic [`CPU_XLEN-1:0]      rs_val;
    logic [`CPU_XLEN-1:0]      rt_val;
    logic [`CPU_XLEN-1:0]      alu_b;
    logic [`CPU_XLEN-1:0]      alu_result;
    logic                      alu_zero;
    logic                      reg_wr_en;
    logic [`CPU_REG_IDX_W-1:0] reg_wr_idx;
    logic [`CPU_XLEN-1:0]      reg_wr_data;

    cpu_control control_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .load_sel    (load_sel),
        .load_word   (load_word),
        .imem_data   (imem_data),
        .dmem_data   (dmem_data),
        .dec         (dec),
        .rs_val      (rs_val),
        .rt_val      (rt_val),
        .alu_result  (alu_result),
        .alu_zero    (alu_zero),
        .imem_wr     (imem_wr),
        .dmem_wr     (dmem_wr),
        .imem_addr   (imem_addr),
        .dmem_addr   (dmem_addr),
        .ir          (ir),
        .alu_b       (alu_b),
        .reg_wr_en   (reg_wr_en),
        .reg_wr_idx  (reg_wr_idx),
        .reg_wr_data (reg_wr_data),
        .done        (done)
    );

    word_memory #(.depth(`CPU_IMEM_DEPTH)) imem_i (
        .clk     (clk),
        .wr      (imem_wr),
        .rd_addr (imem_addr),
        .rd_data (imem_data)
    );

    word_memory #(.depth(`CPU_DMEM_DEPTH)) dmem_i (
        .clk     (clk),
        .wr      (dmem_wr),
        .rd_addr (dmem_addr),
        .rd_data (dmem_data)
    );

    reg_file regs_i (
        .clk     (clk),
        .rst     (rst),
        .rs_idx  (ir.rs),
        .rt_idx  (ir.rt),
        .wr_en   (reg_wr_en),
        .wr_idx  (reg_wr_idx),
        .wr_data (reg_wr_data),
        .rs_val  (rs_val),
        .rt_val  (rt_val)
    );

    instr_decoder decoder_i (
        .ir  (ir),
        .dec (dec)
    );

    alu alu_i (
        .op     (dec.alu_op),
        .a      (rs_val),
        .b      (alu_b),
        .shamt  (ir.shamt),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // Load words share the data memory port but are not program stores
    // Once start is high only sw drives this port
    assign store.en   = dmem_wr.en && start;
    assign store.addr = dmem_wr.addr;
    assign store.data = dmem_wr.data;

endmodule

//--- cpu_checker.sv
//**************************************
// CPU checker
// Compares store events and done
//**************************************
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpu_checker import core_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       done,
    input  mem_write_t store,
    input  logic       finish,
    output int         passed,
    output int         failed,
    output logic       finished
);

    // Expected stores, filled by the testbench before reset ends
    mem_write_t expected [$];
    int         seen;
    int         load_errors;
    int         end_errors;
    logic       load_open;
    logic       done_seen;

    task automatic add_expected(input logic [`CPU_ADDR_W-1:0] addr,
                                input logic [`CPU_XLEN-1:0] data);
        mem_write_t entry;
        entry.en   = 1'b1;
        entry.addr = addr;
        entry.data = data;
        expected.push_back(entry);
    endtask

    task automatic report_test(input string name, input logic ok);
        if (ok) begin
            passed++;
            $display("PASS  %s", name);
        end else begin
            failed++;
            $display("FAIL  %s", name);
        end
    endtask

    // One store event, matched against the next expected entry
    task automatic check_store();
        string name;
        name = $sformatf("store %0d", seen + 1);
        if (seen >= expected.size()) begin
            $display("[ERROR] %0t: extra store of 0x%08h to address 0x%02h",
                     $time, store.data, store.addr);
            report_test("no extra store", 1'b0);
        end else if (store.addr !== expected[seen].addr ||
                     store.data !== expected[seen].data) begin
            $display("[ERROR] %0t: %s wrote 0x%08h to 0x%02h, expected 0x%08h to 0x%02h",
                     $time, name, store.data, store.addr,
                     expected[seen].data, expected[seen].addr);
            report_test(name, 1'b0);
            seen++;
        end else begin
            report_test(name, 1'b1);
            seen++;
        end
    endtask

    // Sampled on the falling edge, half a cycle away from any DUT update
    always @(negedge clk) begin
        if (rst) begin
            seen        = 0;
            load_errors = 0;
            end_errors  = 0;
            passed      = 0;
            failed      = 0;
            load_open   = 1'b1;
            done_seen   = 1'b0;
            finished    = 1'b0;
        end
        if (load_open) begin
            // Reset and loading must show neither done nor a store
            if (done !== 1'b0 || store.en !== 1'b0) begin
                load_errors++;
                $display("[ERROR] %0t: done=%b store.en=%b during reset or loading",
                         $time, done, store.en);
            end
            if (!rst && start) begin
                load_open = 1'b0;
                report_test("reset and load", load_errors == 0);
            end
        end else if (!finished) begin
            if (store.en === 1'b1) begin
                // Nothing may be stored once the core has halted
                if (done_seen) begin
                    end_errors++;
                end
                check_store();
            end else if (store.en !== 1'b0) begin
                end_errors++;
                $display("The store enable was unknown at time %0t", $time);
            end
            if (done_seen && done !== 1'b1) begin
                end_errors++;
                $display("[ERROR] %0t: done fell after it had risen", $time);
            end
            if (done === 1'b1 && !done_seen) begin
                done_seen = 1'b1;
                if (seen != expected.size()) begin
                    end_errors++;
                    $display("[ERROR] %0t: done rose after %0d of %0d expected stores",
                             $time, seen, expected.size());
                end
            end
            if (finish) begin
                report_test("end of program",
                            end_errors == 0 && seen == expected.size());
                finished = 1'b1;
            end
        end
    end

endmodule

//--- tb_cpu.sv
//**************************************
// CPU testbench
// Loads a program from a file and runs it
//**************************************
`timescale 1ns/100ps
`include "cpu_defines.svh"

module tb_cpu import core_pkg::*; ();

    localparam int reset_cycles = 16;
    localparam int entry_count  = 128;
    localparam int margin       = 64;
    localparam int watch_cycles = 8;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 start;
    logic                 load_sel;
    logic [`CPU_XLEN-1:0] load_word;
    logic                 done;
    mem_write_t           store;
    logic                 finish;
    int                   passed;
    int                   failed;
    logic                 finished;

    // Tag in [43:40], address in [39:32], word in [31:0]
    logic [43:0]          entries [entry_count];
    logic [`CPU_XLEN-1:0] imem_words [$];
    logic [`CPU_XLEN-1:0] dmem_words [$];
    int                   exec_count;
    int                   expected_count;
    int                   cycle_limit = 0;
    int                   cycles = 0;
    logic                 data_ok;

    always #4 clk = ~clk;

    cpu_top cpu_top_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .load_sel  (load_sel),
        .load_word (load_word),
        .done      (done),
        .store     (store)
    );

    cpu_checker checker_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .done     (done),
        .store    (store),
        .finish   (finish),
        .passed   (passed),
        .failed   (failed),
        .finished (finished)
    );

    // The limit covers reset, loading, four cycles per instruction and a margin
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not end within %0d clock cycles", cycle_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic read_testdata();
        logic [3:0] tag;
        for (int i = 0; i < entry_count; i++) begin
            entries[i] = '0;
        end
        $readmemh("cpu_testdata.txt", entries);
        for (int i = 0; i < entry_count; i++) begin
            tag = entries[i][43:40];
            case (tag)
                4'h1: imem_words.push_back(entries[i][31:0]);
                4'h2: dmem_words.push_back(entries[i][31:0]);
                4'h3: begin
                    checker_i.add_expected(entries[i][39:32], entries[i][31:0]);
                    expected_count++;
                end
                4'h4: exec_count = entries[i][31:0];
                default: ;
            endcase
        end
    endtask

    // Holds one load word for exactly one clock cycle
    task automatic drive_load_word(input logic sel, input logic [`CPU_XLEN-1:0] word);
        load_sel  = sel;
        load_word = word;
        @(posedge clk);
        #1;
    endtask

    initial begin
        rst            = 1'b1;
        start          = 1'b0;
        load_sel       = 1'b0;
        load_word      = '0;
        finish         = 1'b0;
        exec_count     = 0;
        expected_count = 0;
        read_testdata();
        data_ok = (imem_words.size() > 0) && (exec_count > 0) && (expected_count > 0);
        if (!data_ok) begin
            $display("The test data in cpu_testdata.txt is missing or incomplete");
        end
        cycle_limit = reset_cycles + imem_words.size() + dmem_words.size() +
                      4 * exec_count + margin;

        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;

        // Every cycle with start low writes a word, so the first goes out with reset release
        for (int i = 0; i < imem_words.size(); i++) begin
            drive_load_word(1'b0, imem_words[i]);
        end
        for (int i = 0; i < dmem_words.size(); i++) begin
            drive_load_word(1'b1, dmem_words[i]);
        end
        start     = 1'b1;
        load_sel  = 1'b0;
        load_word = '0;

        while (done !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        // Watch a few more cycles so that done holding and late stores are seen
        repeat (watch_cycles) @(posedge clk);
        #1;
        finish = 1'b1;
        while (finished !== 1'b1) begin
            @(posedge clk);
            #1;
        end

        $display("Summary: %0d tests passed, %0d tests failed", passed, failed);
        if (data_ok && failed == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
isa_pkg.sv
core_pkg.sv
word_memory.sv
reg_file.sv
instr_decoder.sv
alu.sv
cpu_control.sv
cpu_top.sv
cpu_checker.sv
tb_cpu.sv

//--- Bender.yml
package:
  name: cpu_core

export_include_dirs:
  - .

sources:
  - isa_pkg.sv
  - core_pkg.sv
  - word_memory.sv
  - reg_file.sv
  - instr_decoder.sv
  - alu.sv
  - cpu_control.sv
  - cpu_top.sv
  - target: test
    files:
      - cpu_checker.sv
      - tb_cpu.sv

//--- cpu_testdata.txt
// Each entry is TAAWWWWWWWW in hex: T is the tag, AA an address, WWWWWWWW a word
// Tags are 1 program word, 2 data word, 3 expected store (AA, WW), 4 executed count
// Program 0..11: lw r1, lw r2, then add, sub, and, or, slt, each stored with sw
10020010000 10020020001 10000221800 10024030010 10000221801 10024030011
1000C221800 10024030012 10010221800 10024030013 1004C411800 10024030014
// Program 12..26: sll, srl, addi, andi, ori, slti with stores, then lw r4, addi, sw
1001C201900 10024030015 1001C401F01 10024030016 1000423FF9C 10024030017
1001443FF00 10024030018 10018238001 10024030019 1005043FFF1 1002403001A
10020040002 10004840003 1002404001B
// Program 27..37: beq and bne both ways and j, wrong paths store to 0x3F
10028210001 1002400003F 10028220001 10024010020 1002C220001 1002400003F
1002C210001 10024020021 10040000025 1002400003F 1002424FFE6
// Data words at addresses 0, 1 and 2
2000000003C 200FFFFFFF0 20000000005
// Expected stores in order
3100000002C 3110000004C 31200000030 313FFFFFFFC 31400000001 315000003C0
3160000000F 317FFFFFFD8 3180000FF00 3190000803D 31A00000001 31B00000008
3200000003C 321FFFFFFF0 32200000008
// Instructions executed, with three skipped by the branches and the jump
40000000023
